// File: eightbit_params.svh
`ifndef EIGHTBIT_PARAMS_SVH
`define EIGHTBIT_PARAMS_SVH

// Data path and address width.
`define EB_M_WIDTH 8

// Number of general registers.
`define EB_REG_CNT 16

// Bytes per instruction, also the sequential pc step.
`define EB_INST_BYTES 2

// Size of the external byte memory.
`define EB_MEM_SIZE 256

`endif

// File: eightbit_pkg.sv
`include "eightbit_params.svh"

package eightbit_pkg;

    typedef logic [`EB_M_WIDTH-1:0] word_t;
    typedef logic [`EB_INST_BYTES*`EB_M_WIDTH-1:0] inst_t;
    typedef logic [$clog2(`EB_REG_CNT)-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_LI    = 4'd0,
        OP_ADDI  = 4'd1,
        OP_ADD   = 4'd2,
        OP_SUB   = 4'd3,
        OP_AND   = 4'd4,
        OP_OR    = 4'd5,
        OP_XOR   = 4'd6,
        OP_LOAD  = 4'd7,
        OP_STORE = 4'd8,
        OP_BEQ   = 4'd9,
        OP_BNE   = 4'd10,
        OP_JAL   = 4'd11,
        OP_HALT  = 4'd15
    } opcode_t;

    // Encoded as {enable, ready} of a stage.
    typedef enum logic [1:0] {
        STATE_IDLE     = 2'b00,
        STATE_BUSY     = 2'b10,
        STATE_COMPLETE = 2'b11
    } stage_state_t;

endpackage

// File: fetch.sv
`timescale 1ns/1ps

module fetch import eightbit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  en,
    input  word_t pc,
    input  logic  mem_ready,
    input  word_t data_in,
    output logic  mem_req,
    output word_t addr,
    output inst_t inst_out,
    output logic  ready
);

    stage_state_t state;
    logic         lo_phase;
    word_t        hi_byte;

    // The request goes out in the first enabled cycle, even from IDLE.
    assign mem_req = en && (state != STATE_COMPLETE);
    assign addr    = pc + word_t'(lo_phase);
    assign ready   = en && (state == STATE_COMPLETE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= STATE_IDLE;
            lo_phase <= 1'b0;
        end else if (!en) begin
            // Dropped enable abandons the fetch and any pending ready.
            state    <= STATE_IDLE;
            lo_phase <= 1'b0;
        end else begin
            case (state)
                STATE_IDLE: state <= STATE_BUSY;
                STATE_BUSY: begin
                    if (mem_ready) begin
                        lo_phase <= ~lo_phase;
                        if (lo_phase) begin
                            state <= STATE_COMPLETE;
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (en && state == STATE_BUSY && mem_ready) begin
            if (lo_phase) begin
                inst_out <= {hi_byte, data_in};
            end else begin
                hi_byte <= data_in;
            end
        end
    end

endmodule

// File: decode.sv
`timescale 1ns/1ps

`include "eightbit_params.svh"

module decode import eightbit_pkg::*; (
    input  inst_t     inst,
    output opcode_t   op,
    output reg_addr_t rd,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output word_t     imm4_s,
    output word_t     imm4_z,
    output word_t     imm8,
    output logic      writes_rd
);

    assign op  = opcode_t'(inst[15:12]);
    assign rd  = inst[11:8];
    assign rs1 = inst[7:4];
    assign rs2 = inst[3:0];

    assign imm4_s = {{(`EB_M_WIDTH-4){inst[3]}}, inst[3:0]};
    assign imm4_z = {{(`EB_M_WIDTH-4){1'b0}}, inst[3:0]};
    assign imm8   = inst[7:0];

    // Stores, branches, HALT and undefined codes leave rd alone.
    always_comb begin
        case (op)
            OP_LI, OP_ADDI, OP_ADD, OP_SUB,
            OP_AND, OP_OR, OP_XOR,
            OP_LOAD, OP_JAL: begin
                writes_rd = 1'b1;
            end
            default: begin
                writes_rd = 1'b0;
            end
        endcase
    end

endmodule

// File: exec.sv
`timescale 1ns/1ps

`include "eightbit_params.svh"

module exec import eightbit_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    en,
    input  opcode_t op,
    input  word_t   pc_in,
    input  word_t   rs1_val,
    input  word_t   rs2_val,
    input  word_t   rd_val,
    input  word_t   imm4_s,
    input  word_t   imm4_z,
    input  word_t   imm8,
    input  logic    mem_ready,
    input  word_t   mem_data_in,
    output logic    mem_req,
    output logic    mem_we,
    output word_t   mem_addr,
    output word_t   mem_data_out,
    output word_t   val_out,
    output word_t   pc_out,
    output logic    flush,
    output logic    halt,
    output logic    ready
);

    stage_state_t state;
    word_t        alu_val;
    word_t        target;
    word_t        seq_pc;
    logic         taken;
    logic         is_mem;

    assign seq_pc = pc_in + word_t'(`EB_INST_BYTES);
    assign is_mem = (op == OP_LOAD) || (op == OP_STORE);

    always_comb begin
        alu_val = '0;
        target  = pc_in + (imm4_s << 1);
        taken   = 1'b0;
        case (op)
            OP_LI:   alu_val = imm8;
            OP_ADDI: alu_val = rs1_val + imm4_s;
            OP_ADD:  alu_val = rs1_val + rs2_val;
            OP_SUB:  alu_val = rs1_val - rs2_val;
            OP_AND:  alu_val = rs1_val & rs2_val;
            OP_OR:   alu_val = rs1_val | rs2_val;
            OP_XOR:  alu_val = rs1_val ^ rs2_val;
            OP_BEQ:  taken = (rd_val == rs1_val);
            OP_BNE:  taken = (rd_val != rs1_val);
            OP_JAL: begin
                alu_val = seq_pc;
                target  = pc_in + (imm8 << 1);
                taken   = 1'b1;
            end
            default: ;
        endcase
    end

    // One memory access per LOAD or STORE, held until the arbiter answers.
    assign mem_req      = (state == STATE_BUSY);
    assign mem_we       = (op == OP_STORE);
    assign mem_addr     = rs1_val + imm4_z;
    assign mem_data_out = rd_val;
    assign ready        = en && (state == STATE_COMPLETE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STATE_IDLE;
            flush <= 1'b0;
            halt  <= 1'b0;
        end else begin
            case (state)
                STATE_IDLE: begin
                    if (en) begin
                        flush <= taken;
                        halt  <= (op == OP_HALT);
                        state <= is_mem ? STATE_BUSY : STATE_COMPLETE;
                    end
                end
                STATE_BUSY: begin
                    if (mem_ready) begin
                        state <= STATE_COMPLETE;
                    end
                end
                default: begin
                    if (!en) begin
                        state <= STATE_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == STATE_IDLE && en) begin
            val_out <= alu_val;
            pc_out  <= taken ? target : seq_pc;
        end else if (state == STATE_BUSY && mem_ready) begin
            val_out <= mem_data_in;
        end
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

`include "eightbit_params.svh"

module regfile import eightbit_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr_a,
    input  reg_addr_t raddr_b,
    input  reg_addr_t raddr_c,
    output word_t     rdata_a,
    output word_t     rdata_b,
    output word_t     rdata_c
);

    word_t regs [`EB_REG_CNT];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `EB_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Third port serves rd for STORE data and branch compares.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign rdata_c = regs[raddr_c];

endmodule

// File: mem_arb.sv
`timescale 1ns/1ps

module mem_arb import eightbit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  fetch_req,
    input  word_t fetch_addr,
    input  logic  exec_req,
    input  logic  exec_we,
    input  word_t exec_addr,
    input  word_t exec_wdata,
    output logic  fetch_ready,
    output logic  exec_ready,
    output word_t addr,
    output word_t data_out,
    output logic  we
);

    logic grant_fetch;
    logic grant_exec;

    // A client whose ready is due this cycle still holds its request.
    assign grant_exec  = exec_req && !exec_ready;
    assign grant_fetch = fetch_req && !fetch_ready && !grant_exec;

    assign addr     = grant_exec ? exec_addr : fetch_addr;
    assign data_out = grant_exec ? exec_wdata : '0;
    assign we       = grant_exec && exec_we;

    // Memory answers one cycle after the address, so ready lags the grant.
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_ready <= 1'b0;
            exec_ready  <= 1'b0;
        end else begin
            fetch_ready <= grant_fetch;
            exec_ready  <= grant_exec;
        end
    end

endmodule

// File: eightbit.sv
`timescale 1ns/1ps

`include "eightbit_params.svh"

module eightbit import eightbit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t data_in,
    output word_t addr,
    output word_t data_out,
    output logic  we,
    output logic  halted
);

    word_t        pc;
    logic         fetch_en, fetch_ready, fetch_mem_req, fetch_mem_ready;
    word_t        fetch_addr;
    inst_t        fetch_inst;
    logic         exec_en, exec_ready, exec_flush, exec_halt;
    logic         exec_mem_req, exec_mem_we, exec_mem_ready;
    word_t        exec_mem_addr, exec_mem_wdata, exec_val_out, exec_pc_out;
    inst_t        exec_inst;
    word_t        exec_pc;
    opcode_t      dec_op;
    reg_addr_t    dec_rd, dec_rs1, dec_rs2;
    word_t        dec_imm4_s, dec_imm4_z, dec_imm8;
    logic         dec_writes_rd;
    word_t        rs1_val, rs2_val, rd_val;
    stage_state_t fetch_state, exec_state;
    logic         start_fetch, handoff, exec_done;

    assign fetch_state = stage_state_t'({fetch_en, fetch_ready});
    assign exec_state  = stage_state_t'({exec_en, exec_ready});

    assign start_fetch = (fetch_state == STATE_IDLE) && !halted;
    assign handoff     = (fetch_state == STATE_COMPLETE) && (exec_state == STATE_IDLE) && !halted;
    assign exec_done   = (exec_state == STATE_COMPLETE);

    fetch u_fetch (
        .clk(clk), .rst(rst), .en(fetch_en), .pc(pc),
        .mem_ready(fetch_mem_ready), .data_in(data_in),
        .mem_req(fetch_mem_req), .addr(fetch_addr),
        .inst_out(fetch_inst), .ready(fetch_ready)
    );

    decode u_decode (
        .inst(exec_inst), .op(dec_op), .rd(dec_rd), .rs1(dec_rs1), .rs2(dec_rs2),
        .imm4_s(dec_imm4_s), .imm4_z(dec_imm4_z), .imm8(dec_imm8),
        .writes_rd(dec_writes_rd)
    );

    exec u_exec (
        .clk(clk), .rst(rst), .en(exec_en), .op(dec_op), .pc_in(exec_pc),
        .rs1_val(rs1_val), .rs2_val(rs2_val), .rd_val(rd_val),
        .imm4_s(dec_imm4_s), .imm4_z(dec_imm4_z), .imm8(dec_imm8),
        .mem_ready(exec_mem_ready), .mem_data_in(data_in),
        .mem_req(exec_mem_req), .mem_we(exec_mem_we),
        .mem_addr(exec_mem_addr), .mem_data_out(exec_mem_wdata),
        .val_out(exec_val_out), .pc_out(exec_pc_out),
        .flush(exec_flush), .halt(exec_halt), .ready(exec_ready)
    );

    // Writeback lands at the edge that ends the execute stage.
    regfile u_regfile (
        .clk(clk), .rst(rst), .we(exec_done && dec_writes_rd),
        .waddr(dec_rd), .wdata(exec_val_out),
        .raddr_a(dec_rs1), .raddr_b(dec_rs2), .raddr_c(dec_rd),
        .rdata_a(rs1_val), .rdata_b(rs2_val), .rdata_c(rd_val)
    );

    mem_arb u_mem_arb (
        .clk(clk), .rst(rst),
        .fetch_req(fetch_mem_req), .fetch_addr(fetch_addr),
        .exec_req(exec_mem_req), .exec_we(exec_mem_we),
        .exec_addr(exec_mem_addr), .exec_wdata(exec_mem_wdata),
        .fetch_ready(fetch_mem_ready), .exec_ready(exec_mem_ready),
        .addr(addr), .data_out(data_out), .we(we)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= '0;
            fetch_en <= 1'b0;
            exec_en  <= 1'b0;
            halted   <= 1'b0;
        end else begin
            if (start_fetch) begin
                fetch_en <= 1'b1;
            end
            // Next fetch overlaps execution of the handed-off instruction.
            if (handoff) begin
                fetch_en <= 1'b0;
                exec_en  <= 1'b1;
                pc       <= pc + word_t'(`EB_INST_BYTES);
            end
            if (exec_done) begin
                exec_en <= 1'b0;
                if (exec_flush) begin
                    pc       <= exec_pc_out;
                    fetch_en <= 1'b0;
                end
                if (exec_halt) begin
                    halted   <= 1'b1;
                    fetch_en <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (handoff) begin
            exec_inst <= fetch_inst;
            exec_pc   <= pc;
        end
    end

endmodule

// File: eightbit_monitor.sv
`timescale 1ns/1ps

`include "eightbit_params.svh"

module eightbit_monitor import eightbit_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  int    test_id,
    input  logic  we,
    input  logic  halted,
    input  word_t addr,
    input  word_t data_out,
    input  word_t exp_addr [`EB_MEM_SIZE],
    input  word_t exp_data [`EB_MEM_SIZE],
    input  word_t exp_mem  [`EB_MEM_SIZE],
    input  word_t mem      [`EB_MEM_SIZE],
    input  int    exp_count,
    output logic  done,
    output int    tests_run,
    output int    tests_failed,
    output int    total_errors
);

    int store_idx;
    int test_errs;
    int after_rst;

    initial begin
        done = 1'b0;
        tests_run = 0;
        tests_failed = 0;
        total_errors = 0;
    end

    task automatic check_byte(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            $display("FAIL t=%0t %s: got %02h, expected %02h", $time, name, got, want);
            test_errs++;
        end
    endtask

    // Sampled mid-cycle, where the bus has settled.
    always @(negedge clk) begin
        if (rst) begin
            store_idx = 0;
            test_errs = 0;
            after_rst = 0;
            done = 1'b0;
        end else if (!done) begin
            if (after_rst == 0) begin
                check_byte("we", {7'b0, we}, 8'h00);
                check_byte("halted", {7'b0, halted}, 8'h00);
            end
            // First fetch goes to address 0.
            if (after_rst < 2) begin
                check_byte("addr", addr, 8'h00);
                after_rst++;
            end
            if (we) begin
                if (store_idx >= exp_count) begin
                    $display("test %0d: store to %02h beyond the %0d expected stores",
                             test_id, addr, exp_count);
                    test_errs++;
                end else begin
                    check_byte("addr", addr, exp_addr[8'(store_idx)]);
                    check_byte("data_out", data_out, exp_data[8'(store_idx)]);
                end
                store_idx++;
            end
            if (halted) begin
                if (store_idx != exp_count) begin
                    $display("test %0d: saw %0d stores where %0d were expected",
                             test_id, store_idx, exp_count);
                    test_errs++;
                end
                for (int i = 128; i < `EB_MEM_SIZE; i++) begin
                    check_byte($sformatf("mem[%02h]", i), mem[8'(i)], exp_mem[8'(i)]);
                end
                tests_run++;
                if (test_errs != 0) begin
                    tests_failed++;
                end
                total_errors += test_errs;
                $display("test %0d: %s, %0d stores, %0d errors", test_id,
                         (test_errs == 0) ? "ok" : "failed", store_idx, test_errs);
                done = 1'b1;
            end
        end
    end

endmodule

// File: eightbit_checker.sv
`timescale 1ns/1ps

module eightbit_checker import eightbit_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  we,
    input logic  halted,
    input word_t addr
);

    word_t addr_mid;
    logic  we_mid;

    // Bus state halfway through the cycle.
    always_ff @(negedge clk) begin
        addr_mid <= addr;
        we_mid   <= we;
    end

    // Outputs are quiet once reset has been seen at one edge.
    reset_quiet: assert property (@(posedge clk) rst && $past(rst) |-> !we && !halted)
        else $error("we or halted high during reset");

    halt_sticky: assert property (@(posedge clk) $fell(halted) |-> $past(rst))
        else $error("halted fell without reset");

    store_addr_stable: assert property (@(posedge clk) we && we_mid |-> addr == addr_mid)
        else $error("addr moved while we was high");

endmodule

bind eightbit eightbit_checker chk0 (
    .clk(clk), .rst(rst), .we(we), .halted(halted), .addr(addr)
);

// File: eightbit_tb.sv
`timescale 1ns/1ps

`include "eightbit_params.svh"

module eightbit_tb import eightbit_pkg::*; ();

    logic        clk;
    logic        rst;
    logic        we;
    logic        halted;
    logic        mon_done;
    logic        timed_out;
    word_t       data_in;
    word_t       addr;
    word_t       data_out;
    word_t       wp;
    logic [31:0] lfsr;
    int          test_id;
    int          exp_count;
    int          tests_run;
    int          tests_failed;
    int          total_errors;

    word_t mem      [`EB_MEM_SIZE];
    word_t img      [`EB_MEM_SIZE];
    word_t exp_addr [`EB_MEM_SIZE];
    word_t exp_data [`EB_MEM_SIZE];
    word_t exp_mem  [`EB_MEM_SIZE];

    eightbit dut0 (
        .clk(clk), .rst(rst), .data_in(data_in),
        .addr(addr), .data_out(data_out), .we(we), .halted(halted)
    );

    eightbit_monitor mon0 (
        .clk(clk), .rst(rst), .test_id(test_id),
        .we(we), .halted(halted), .addr(addr), .data_out(data_out),
        .exp_addr(exp_addr), .exp_data(exp_data), .exp_mem(exp_mem), .mem(mem),
        .exp_count(exp_count), .done(mon_done), .tests_run(tests_run),
        .tests_failed(tests_failed), .total_errors(total_errors)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Synchronous memory. The bus is sampled mid-cycle.
    // Read data shows up one cycle after the address.
    initial begin
        word_t a;
        word_t d;
        word_t q;
        logic  w;
        data_in = '0;
        forever begin
            @(negedge clk);
            a = addr;
            w = we;
            d = data_out;
            @(posedge clk);
            q = mem[a];
            #1;
            if (w) begin
                mem[a] = d;
            end
            data_in = q;
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    function automatic inst_t enc(input opcode_t op, input logic [3:0] a,
                                  input logic [3:0] b, input logic [3:0] c);
        return {op, a, b, c};
    endfunction

    task automatic emit(input inst_t i);
        img[wp] = i[15:8];
        img[wp + 8'd1] = i[7:0];
        wp = wp + 8'd2;
    endtask

    task automatic clear_image();
        for (int i = 0; i < `EB_MEM_SIZE; i++) begin
            img[8'(i)] = 8'(i * 29 + 7) ^ 8'(i >> 3);
        end
        wp = '0;
    endtask

    task automatic build_alu();
        logic [7:0] v;
        emit(enc(OP_LI, 4'd15, 4'h8, 4'h0));
        for (int r = 1; r <= 4; r++) begin
            rand_bits(8, v);
            emit(enc(OP_LI, 4'(r), v[7:4], v[3:0]));
        end
        rand_bits(4, v);
        emit(enc(OP_ADDI, 4'd5, 4'd1, v[3:0]));
        emit(enc(OP_ADD, 4'd6, 4'd1, 4'd2));
        emit(enc(OP_SUB, 4'd7, 4'd3, 4'd4));
        emit(enc(OP_AND, 4'd8, 4'd1, 4'd3));
        emit(enc(OP_OR, 4'd9, 4'd2, 4'd4));
        emit(enc(OP_XOR, 4'd10, 4'd1, 4'd4));
        for (int r = 1; r <= 10; r++) begin
            emit(enc(OP_STORE, 4'(r), 4'd15, 4'(r)));
        end
        emit(enc(OP_HALT, 4'd0, 4'd0, 4'd0));
    endtask

    task automatic build_ls();
        logic [7:0] v;
        emit(enc(OP_LI, 4'd15, 4'h8, 4'h0));
        rand_bits(8, v);
        emit(enc(OP_LI, 4'd1, v[7:4], v[3:0]));
        rand_bits(8, v);
        emit(enc(OP_LI, 4'd2, v[7:4], v[3:0]));
        emit(enc(OP_STORE, 4'd1, 4'd15, 4'd1));
        emit(enc(OP_STORE, 4'd2, 4'd15, 4'd2));
        emit(enc(OP_LOAD, 4'd3, 4'd15, 4'd1));
        emit(enc(OP_LOAD, 4'd4, 4'd15, 4'd2));
        emit(enc(OP_STORE, 4'd3, 4'd15, 4'd3));
        emit(enc(OP_STORE, 4'd4, 4'd15, 4'd4));
        // Reads a byte of the preset fill pattern.
        emit(enc(OP_LOAD, 4'd5, 4'd15, 4'd9));
        emit(enc(OP_STORE, 4'd5, 4'd15, 4'd5));
        emit(enc(OP_ADD, 4'd6, 4'd3, 4'd4));
        emit(enc(OP_STORE, 4'd6, 4'd15, 4'd6));
        emit(enc(OP_HALT, 4'd0, 4'd0, 4'd0));
    endtask

    task automatic build_ctrl();
        emit(enc(OP_LI, 4'd15, 4'h8, 4'h0));
        emit(enc(OP_LI, 4'd1, 4'd0, 4'd5));
        emit(enc(OP_LI, 4'd2, 4'd0, 4'd5));
        emit(enc(OP_LI, 4'd3, 4'd0, 4'd7));
        emit(enc(OP_BEQ, 4'd1, 4'd2, 4'd2));
        emit(enc(OP_STORE, 4'd3, 4'd15, 4'd0));
        emit(enc(OP_STORE, 4'd1, 4'd15, 4'd1));
        emit(enc(OP_BNE, 4'd1, 4'd2, 4'd2));
        emit(enc(OP_STORE, 4'd2, 4'd15, 4'd2));
        emit(enc(OP_BNE, 4'd1, 4'd3, 4'd2));
        emit(enc(OP_STORE, 4'd3, 4'd15, 4'd3));
        emit(enc(OP_JAL, 4'd4, 4'd0, 4'd2));
        emit(enc(OP_STORE, 4'd1, 4'd15, 4'd4));
        emit(enc(OP_STORE, 4'd4, 4'd15, 4'd5));
        emit(enc(OP_BEQ, 4'd1, 4'd3, 4'd2));
        emit(enc(OP_STORE, 4'd3, 4'd15, 4'd6));
        emit(enc(OP_HALT, 4'd0, 4'd0, 4'd0));
    endtask

    // r15 stays the data base, so random writes only go to r0..r14.
    task automatic build_random();
        logic [7:0] v;
        logic [3:0] rd;
        logic [3:0] rs;
        logic [3:0] lo;
        opcode_t    op;
        int         max_off;
        emit(enc(OP_LI, 4'd15, 4'h8, 4'h0));
        for (int i = 1; i < 19; i++) begin
            rand_bits(8, v);
            op = opcode_t'(4'(v % 8'd12));
            rand_bits(4, v);
            rd = (v[3:0] == 4'd15) ? 4'd14 : v[3:0];
            rand_bits(4, v);
            rs = v[3:0];
            rand_bits(4, v);
            lo = v[3:0];
            max_off = (19 - i > 7) ? 7 : 19 - i;
            case (op)
                OP_LOAD, OP_STORE: emit(enc(op, rd, 4'd15, lo));
                OP_BEQ, OP_BNE: emit(enc(op, rd, rs, 4'(1 + int'(lo) % max_off)));
                OP_JAL: emit(enc(op, rd, 4'd0, 4'(1 + int'(lo) % max_off)));
                default: emit(enc(op, rd, rs, lo));
            endcase
        end
        emit(enc(OP_HALT, 4'd0, 4'd0, 4'd0));
    endtask

    // Reference model of the instruction set, run on the program image.
    function automatic logic run_model();
        word_t      m [`EB_MEM_SIZE];
        word_t      r [`EB_REG_CNT];
        word_t      pc;
        word_t      nxt;
        word_t      a;
        word_t      s4;
        word_t      z4;
        word_t      i8;
        inst_t      ins;
        logic [3:0] rd;
        logic [3:0] rs1;
        logic [3:0] lo;
        logic       done;
        int         steps;
        for (int i = 0; i < `EB_MEM_SIZE; i++) begin
            m[8'(i)] = img[8'(i)];
        end
        for (int i = 0; i < `EB_REG_CNT; i++) begin
            r[4'(i)] = '0;
        end
        exp_count = 0;
        pc = '0;
        done = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            ins = {m[pc], m[pc + 8'd1]};
            rd = ins[11:8];
            rs1 = ins[7:4];
            lo = ins[3:0];
            s4 = {{4{lo[3]}}, lo};
            z4 = {4'h0, lo};
            i8 = ins[7:0];
            nxt = pc + 8'd2;
            case (ins[15:12])
                OP_LI:   r[rd] = i8;
                OP_ADDI: r[rd] = r[rs1] + s4;
                OP_ADD:  r[rd] = r[rs1] + r[lo];
                OP_SUB:  r[rd] = r[rs1] - r[lo];
                OP_AND:  r[rd] = r[rs1] & r[lo];
                OP_OR:   r[rd] = r[rs1] | r[lo];
                OP_XOR:  r[rd] = r[rs1] ^ r[lo];
                OP_LOAD: r[rd] = m[r[rs1] + z4];
                OP_STORE: begin
                    a = r[rs1] + z4;
                    m[a] = r[rd];
                    exp_addr[8'(exp_count)] = a;
                    exp_data[8'(exp_count)] = r[rd];
                    exp_count++;
                end
                OP_BEQ: if (r[rd] == r[rs1]) nxt = pc + (s4 << 1);
                OP_BNE: if (r[rd] != r[rs1]) nxt = pc + (s4 << 1);
                OP_JAL: begin
                    r[rd] = pc + 8'd2;
                    nxt = pc + (i8 << 1);
                end
                OP_HALT: done = 1'b1;
                default: ;
            endcase
            pc = nxt;
            steps++;
        end
        for (int i = 0; i < `EB_MEM_SIZE; i++) begin
            exp_mem[8'(i)] = m[8'(i)];
        end
        return done;
    endfunction

    task automatic run_test(input int id, output logic stuck);
        int cycles;
        stuck = 1'b0;
        @(posedge clk);
        #1;
        rst = 1'b1;
        test_id = id;
        if (!run_model()) begin
            $display("test %0d: reference model never reached HALT", id);
            stuck = 1'b1;
        end
        for (int i = 0; i < `EB_MEM_SIZE; i++) begin
            mem[8'(i)] = img[8'(i)];
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        cycles = 0;
        while (!halted && cycles < 5000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("timeout: test %0d, the core never raised halted", id);
            stuck = 1'b1;
        end else begin
            cycles = 0;
            while (!mon_done && cycles < 10) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            if (!mon_done) begin
                $display("timeout: test %0d, the monitor gave no result", id);
                stuck = 1'b1;
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        test_id = 0;
        timed_out = 1'b0;
        lfsr = 32'h67efb8a5;
        wp = '0;
        for (int t = 0; t < 8 && !timed_out; t++) begin
            clear_image();
            case (t)
                0: build_alu();
                1: build_ls();
                2: build_ctrl();
                default: build_random();
            endcase
            run_test(t, timed_out);
        end
        $display("summary: %0d tests run, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errors);
        if (!timed_out && tests_failed == 0 && tests_run == 8) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: eightbit.f
+incdir+.
eightbit_pkg.sv
fetch.sv
decode.sv
exec.sv
regfile.sv
mem_arb.sv
eightbit.sv
eightbit_monitor.sv
eightbit_checker.sv
eightbit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := eightbit_tb
FILELIST  := eightbit.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
